//--- tb.f
hw/game_pkg.sv
hw/game_if.sv
hw/raster_scan.sv
hw/game_sprite.sv
hw/pixel_mixer.sv
hw/end_of_game_timer.sv
hw/game_master_fsm.sv
hw/game_top.sv
testbench/tb_game.sv

//--- run_sim.sh
#!/bin/bash
# Build with Verilator, run, and decide on the log contents
verilator --binary --timing --assert -f tb.f --top-module tb_game -o tb_game_sim \
    > build.log 2>&1 \
    && ./obj_dir/tb_game_sim > sim.log 2>&1 \
    || { cat build.log sim.log 2>/dev/null; echo "Build or simulation failed"; exit 1; }
cat sim.log
grep -q "Done: errors found" sim.log \
    && { echo "Simulation failed"; exit 1; } \
    || echo "Simulation passed"

//--- testbench/tb_game.sv
module tb_game
    import game_pkg::*;
();

    localparam int SCREEN_W   = 64;
    localparam int SCREEN_H   = 48;
    localparam int TGT_X      = 8;
    localparam int TGT_Y      = 8;
    localparam int TGT_DX     = 4;
    localparam int TRP_X      = 40;
    localparam int TRP_Y      = 40;
    localparam int TRP_DY     = -4;
    localparam int HIT_KEY    = 1;   // Key frame that puts the torpedo into the target
    localparam int ROUND_LEN  = 15;  // Frames per round that ends with the target leaving

    // Eight rounds of frames plus a margin
    localparam longint WATCHDOG_TIME = 8 * ROUND_LEN * SCREEN_W * SCREEN_H * 10 + 100000;

    logic   clk;
    logic   reset;
    logic   key;
    rgb_t   rgb;
    coord_t out_x;
    coord_t out_y;
    logic   rgb_valid;
    logic   game_won;

    int          frame;      // Frame of the current output pixel
    int          exp_x;
    int          exp_y;
    int          key_frame;  // Miss round key frame
    int          errors;
    logic [31:0] lcg_state;
    logic        check_color;
    rgb_t        exp_rgb;

    game_top #(
        .SCREEN_W   (SCREEN_W),
        .SCREEN_H   (SCREEN_H),
        .TARGET_X   (TGT_X),
        .TARGET_Y   (TGT_Y),
        .TARGET_DX  (TGT_DX),
        .TARGET_DY  (0),
        .TORPEDO_X  (TRP_X),
        .TORPEDO_Y  (TRP_Y),
        .TORPEDO_DX (0),
        .TORPEDO_DY (TRP_DY),
        .END_FRAMES (2)
    ) u_game_top (
        .clk       (clk),
        .reset     (reset),
        .key       (key),
        .rgb       (rgb),
        .out_x     (out_x),
        .out_y     (out_y),
        .rgb_valid (rgb_valid),
        .game_won  (game_won)
    );

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic logic in_box(input int x, input int y, input int px, input int py);
        return (x >= px) && (x < px + SPRITE_SIZE) && (y >= py) && (y < py + SPRITE_SIZE);
    endfunction

    // tf frames of target movement, kf frames of torpedo movement
    function automatic rgb_t model_color(input int x, input int y, input int tf, input int kf);
        if (in_box(x, y, TRP_X, TRP_Y + TRP_DY * kf))
            return COLOR_TORPEDO;
        else if (in_box(x, y, TGT_X + TGT_DX * tf, TGT_Y))
            return COLOR_TARGET;
        return COLOR_BACKGROUND;
    endfunction

    function automatic int moved_frames(input int round_frame, input int fire_frame);
        return (round_frame > fire_frame) ? round_frame - fire_frame : 0;
    endfunction

    task automatic report_mismatch(input string name, input int expected, input int actual);
        errors++;
        $display("FAILED t=%0t %s expected %0d got %0d", $time, name, expected, actual);
        $display("Done: errors found");
        $fatal(1, "Mismatch on %s", name);
    endtask

    task automatic press_key(input int abs_frame);
        while (!(frame == abs_frame && exp_y == 24))
            @(negedge clk);
        key = 1'b1;
        @(negedge clk);
        key = 1'b0;
    endtask

    initial
    begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    initial
    begin
        #(WATCHDOG_TIME);
        $display("Timeout: the game did not reach the final frame in time");
        $display("Done: errors found");
        $fatal(1, "Watchdog expired");
    end

    // Expected output pixel, advanced after each valid pixel
    always @(negedge clk)
    begin
        if (rgb_valid)
        begin
            if (exp_x == SCREEN_W - 1)
            begin
                exp_x <= 0;
                if (exp_y == SCREEN_H - 1)
                begin
                    exp_y <= 0;
                    frame <= frame + 1;
                end
                else
                    exp_y <= exp_y + 1;
            end
            else
                exp_x <= exp_x + 1;
        end
    end

    // Frames with well defined sprite positions; round start frames are skipped
    always_comb
    begin
        check_color = 1'b0;
        exp_rgb     = model_color(exp_x, exp_y, frame, 0);
        if (frame <= 12)
            check_color = 1'b1;
        else if (frame >= ROUND_LEN + 1 && frame <= ROUND_LEN + 12)
        begin
            check_color = 1'b1;
            exp_rgb     = model_color(exp_x, exp_y, frame - ROUND_LEN,
                                      moved_frames(frame - ROUND_LEN, key_frame));
        end
        else if (frame >= 2 * ROUND_LEN + 1 && frame <= 2 * ROUND_LEN + 7)
        begin
            check_color = 1'b1;
            exp_rgb     = model_color(exp_x, exp_y, frame - 2 * ROUND_LEN,
                                      moved_frames(frame - 2 * ROUND_LEN, HIT_KEY));
        end
        else if (frame == 40 && exp_y >= 1)
        begin
            check_color = 1'b1;  // Fourth round back at the start
            exp_rgb     = model_color(exp_x, exp_y, 0, 0);
        end
    end

    reset_clears_valid: assert property (@(negedge clk) reset |-> !rgb_valid)
        else report_mismatch("rgb_valid", 0, int'($sampled(rgb_valid)));

    reset_clears_won: assert property (@(negedge clk) reset |-> !game_won)
        else report_mismatch("game_won", 0, int'($sampled(game_won)));

    valid_after_reset: assert property (@(negedge clk) $fell(reset) |-> !rgb_valid ##1 rgb_valid)
        else report_mismatch("rgb_valid", 1, int'($sampled(rgb_valid)));

    valid_stays: assert property (@(negedge clk) disable iff (reset)
        $past(rgb_valid) |-> rgb_valid)
        else report_mismatch("rgb_valid", 1, int'($sampled(rgb_valid)));

    raster_x: assert property (@(negedge clk) disable iff (reset)
        rgb_valid |-> out_x == coord_t'(exp_x))
        else report_mismatch("out_x", $sampled(exp_x), int'($sampled(out_x)));

    raster_y: assert property (@(negedge clk) disable iff (reset)
        rgb_valid |-> out_y == coord_t'(exp_y))
        else report_mismatch("out_y", $sampled(exp_y), int'($sampled(out_y)));

    color_model: assert property (@(negedge clk) disable iff (reset)
        rgb_valid && check_color |-> rgb == exp_rgb)
        else report_mismatch("rgb", int'($sampled(exp_rgb)), int'($sampled(rgb)));

    won_low_on_miss: assert property (@(negedge clk) disable iff (reset)
        frame < 38 |-> !game_won)
        else report_mismatch("game_won", 0, int'($sampled(game_won)));

    won_on_hit: assert property (@(negedge clk) disable iff (reset)
        (frame == 38 && exp_y >= 20) || frame == 39 |-> game_won)
        else report_mismatch("game_won", 1, int'($sampled(game_won)));

    won_clears: assert property (@(negedge clk) disable iff (reset)
        frame == 40 && exp_y >= 1 |-> !game_won)
        else report_mismatch("game_won", 0, int'($sampled(game_won)));

    initial
    begin
        reset     = 1'b1;
        key       = 1'b0;
        frame     = 0;
        exp_x     = 0;
        exp_y     = 0;
        errors    = 0;
        lcg_state = 32'h567e6238;
        lcg_state = lcg_next(lcg_state);
        key_frame = 3 + int'((lcg_state >> 16) % 32'd4);  // Miss window is frames 3 to 6

        repeat (10) @(negedge clk);
        reset = 1'b0;

        press_key(ROUND_LEN + key_frame);  // Second round, torpedo misses
        press_key(2 * ROUND_LEN + HIT_KEY);  // Third round, torpedo hits

        while (frame < 41)
            @(negedge clk);

        if (errors == 0)
            $display("Done: no errors");
        else
            $display("Done: errors found");
        $finish;
    end

endmodule

//--- hw/game_top.sv
module game_top
    import game_pkg::*;
#(
    parameter int SCREEN_W   = 640,
    parameter int SCREEN_H   = 480,
    parameter int TARGET_X   = 16,
    parameter int TARGET_Y   = 40,
    parameter int TARGET_DX  = 2,
    parameter int TARGET_DY  = 0,
    parameter int TORPEDO_X  = 320,
    parameter int TORPEDO_Y  = 440,
    parameter int TORPEDO_DX = 0,
    parameter int TORPEDO_DY = -3,
    parameter int END_FRAMES = 60
)
(
    input  logic   clk,
    input  logic   reset,
    input  logic   key,
    output rgb_t   rgb,
    output coord_t out_x,
    output coord_t out_y,
    output logic   rgb_valid,
    output logic   game_won
);

    pixel_scan_if  scan ();
    sprite_ctrl_if target_ctrl ();
    sprite_ctrl_if torpedo_ctrl ();

    logic target_hit;
    logic torpedo_hit;
    logic collision;
    logic timer_start;
    logic timer_running;

    raster_scan #(
        .SCREEN_W (SCREEN_W),
        .SCREEN_H (SCREEN_H)
    ) u_raster_scan (
        .clk   (clk),
        .reset (reset),
        .scan  (scan)
    );

    game_sprite #(
        .START_X  (TARGET_X),
        .START_Y  (TARGET_Y),
        .DX       (TARGET_DX),
        .DY       (TARGET_DY),
        .SCREEN_W (SCREEN_W),
        .SCREEN_H (SCREEN_H)
    ) u_target (
        .clk   (clk),
        .reset (reset),
        .ctrl  (target_ctrl),
        .scan  (scan),
        .hit   (target_hit)
    );

    game_sprite #(
        .START_X  (TORPEDO_X),
        .START_Y  (TORPEDO_Y),
        .DX       (TORPEDO_DX),
        .DY       (TORPEDO_DY),
        .SCREEN_W (SCREEN_W),
        .SCREEN_H (SCREEN_H)
    ) u_torpedo (
        .clk   (clk),
        .reset (reset),
        .ctrl  (torpedo_ctrl),
        .scan  (scan),
        .hit   (torpedo_hit)
    );

    pixel_mixer u_pixel_mixer (
        .clk         (clk),
        .reset       (reset),
        .scan        (scan),
        .target_hit  (target_hit),
        .torpedo_hit (torpedo_hit),
        .collision   (collision),
        .rgb         (rgb),
        .out_x       (out_x),
        .out_y       (out_y),
        .rgb_valid   (rgb_valid)
    );

    end_of_game_timer #(
        .END_FRAMES (END_FRAMES)
    ) u_end_of_game_timer (
        .clk       (clk),
        .reset     (reset),
        .start     (timer_start),
        .frame_end (scan.frame_end),
        .running   (timer_running)
    );

    game_master_fsm u_game_master_fsm (
        .clk           (clk),
        .reset         (reset),
        .key           (key),
        .collision     (collision),
        .timer_running (timer_running),
        .target        (target_ctrl),
        .torpedo       (torpedo_ctrl),
        .timer_start   (timer_start),
        .game_won      (game_won)
    );

endmodule

//--- hw/game_master_fsm.sv
module game_master_fsm
(
    input  logic           clk,
    input  logic           reset,
    input  logic           key,
    input  logic           collision,
    input  logic           timer_running,
    sprite_ctrl_if.master  target,
    sprite_ctrl_if.master  torpedo,
    output logic           timer_start,
    output logic           game_won
);

    localparam logic [3:0] STATE_START = 4'b0001;
    localparam logic [3:0] STATE_AIM   = 4'b0010;
    localparam logic [3:0] STATE_SHOOT = 4'b0100;
    localparam logic [3:0] STATE_END   = 4'b1000;

    logic [3:0] state;
    logic [3:0] d_state;

    logic       d_target_write_xy;
    logic       d_torpedo_write_xy;
    logic       d_target_write_dxy;
    logic       d_torpedo_write_dxy;
    logic       d_target_enable_update;
    logic       d_torpedo_enable_update;
    logic       d_timer_start;
    logic       d_game_won;

    logic       timer_running_q;
    logic       timer_done;
    logic       end_of_game;

    assign timer_done  = timer_running_q & ~timer_running;  // Falling edge
    assign end_of_game = ~target.within_screen | ~torpedo.within_screen | collision;

    always_comb
    begin
        d_state                 = state;
        d_target_write_xy       = 1'b0;
        d_torpedo_write_xy      = 1'b0;
        d_target_write_dxy      = 1'b0;
        d_torpedo_write_dxy     = 1'b0;
        d_target_enable_update  = 1'b0;
        d_torpedo_enable_update = 1'b0;
        d_timer_start           = 1'b0;
        d_game_won              = game_won;

        case (state)
            STATE_START:
            begin
                d_target_write_xy  = 1'b1;
                d_torpedo_write_xy = 1'b1;
                d_target_write_dxy = 1'b1;
                d_game_won         = 1'b0;
                d_state            = STATE_AIM;
            end

            STATE_AIM:
            begin
                d_target_enable_update = 1'b1;

                if (key)
                begin
                    d_state = STATE_SHOOT;
                end
                else if (end_of_game && !target.write_xy)  // Old position still held
                begin
                    d_timer_start = 1'b1;
                    d_state       = STATE_END;
                end
            end

            STATE_SHOOT:
            begin
                d_torpedo_write_dxy     = 1'b1;
                d_target_enable_update  = 1'b1;
                d_torpedo_enable_update = 1'b1;

                if (collision)
                    d_game_won = 1'b1;

                if (end_of_game)
                begin
                    d_timer_start = 1'b1;
                    d_state       = STATE_END;
                end
            end

            STATE_END:
            begin
                // Overlap pixels later in the frame still count
                if (collision)
                    d_game_won = 1'b1;

                if (timer_done)
                    d_state = STATE_START;
            end

            default:
                d_state = STATE_START;
        endcase
    end

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            state                 <= STATE_START;
            timer_running_q       <= 1'b0;
            target.write_xy       <= 1'b0;
            torpedo.write_xy      <= 1'b0;
            target.write_dxy      <= 1'b0;
            torpedo.write_dxy     <= 1'b0;
            target.enable_update  <= 1'b0;
            torpedo.enable_update <= 1'b0;
            timer_start           <= 1'b0;
            game_won              <= 1'b0;
        end
        else
        begin
            state                 <= d_state;
            timer_running_q       <= timer_running;
            target.write_xy       <= d_target_write_xy;
            torpedo.write_xy      <= d_torpedo_write_xy;
            target.write_dxy      <= d_target_write_dxy;
            torpedo.write_dxy     <= d_torpedo_write_dxy;
            target.enable_update  <= d_target_enable_update;
            torpedo.enable_update <= d_torpedo_enable_update;
            timer_start           <= d_timer_start;
            game_won              <= d_game_won;
        end
    end

    state_one_hot: assert property (@(posedge clk) disable iff (reset) $onehot(state));

endmodule

//--- hw/end_of_game_timer.sv
module end_of_game_timer
#(
    parameter int END_FRAMES = 60
)
(
    input  logic clk,
    input  logic reset,
    input  logic start,
    input  logic frame_end,
    output logic running
);

    localparam int COUNT_W = $clog2(END_FRAMES + 1);

    logic [COUNT_W-1:0] frames_left;

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
            frames_left <= '0;
        else if (start)
            frames_left <= COUNT_W'(END_FRAMES);  // Restart wins over a frame end
        else if (frame_end && frames_left != '0)
            frames_left <= frames_left - 1'b1;
    end

    assign running = (frames_left != '0);

endmodule

//--- hw/pixel_mixer.sv
module pixel_mixer
    import game_pkg::*;
(
    input  logic              clk,
    input  logic              reset,
    pixel_scan_if.sink        scan,
    input  logic              target_hit,
    input  logic              torpedo_hit,
    output logic              collision,
    output rgb_t              rgb,
    output coord_t            out_x,
    output coord_t            out_y,
    output logic              rgb_valid
);

    rgb_t pixel_color;

    // Torpedo is drawn on top of the target
    always_comb
    begin
        if (torpedo_hit)
            pixel_color = COLOR_TORPEDO;
        else if (target_hit)
            pixel_color = COLOR_TARGET;
        else
            pixel_color = COLOR_BACKGROUND;
    end

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            rgb_valid <= 1'b0;
            collision <= 1'b0;
        end
        else
        begin
            rgb_valid <= scan.valid;
            collision <= target_hit & torpedo_hit;  // Both boxes on one pixel
        end
    end

    // Pixel data follows the valid strobe
    always_ff @(posedge clk)
    begin
        rgb   <= pixel_color;
        out_x <= scan.x;
        out_y <= scan.y;
    end

    collision_on_valid_pixel: assert property (@(posedge clk) disable iff (reset)
        collision |-> rgb_valid);

endmodule

//--- hw/game_sprite.sv
module game_sprite
    import game_pkg::*;
#(
    parameter int START_X  = 0,
    parameter int START_Y  = 0,
    parameter int DX       = 0,
    parameter int DY       = 0,
    parameter int SCREEN_W = 640,
    parameter int SCREEN_H = 480
)
(
    input  logic          clk,
    input  logic          reset,
    sprite_ctrl_if.sprite ctrl,
    pixel_scan_if.sink    scan,
    output logic          hit
);

    coord_t pos_x;
    coord_t pos_y;
    delta_t vel_dx;
    delta_t vel_dy;

    coord_t rel_x;
    coord_t rel_y;

    logic   frame_move;

    assign frame_move = scan.frame_end & ctrl.enable_update;

    // Position starts at its load value so frame 0 is drawn correctly
    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            pos_x <= coord_t'(START_X);
            pos_y <= coord_t'(START_Y);
        end
        else if (ctrl.write_xy)
        begin
            pos_x <= coord_t'(START_X);
            pos_y <= coord_t'(START_Y);
        end
        else if (frame_move)
        begin
            // Velocity is sign extended to the coordinate width
            pos_x <= pos_x + coord_t'(vel_dx);
            pos_y <= pos_y + coord_t'(vel_dy);
        end
    end

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            vel_dx <= '0;
            vel_dy <= '0;
        end
        else if (ctrl.write_dxy)
        begin
            vel_dx <= delta_t'(DX);
            vel_dy <= delta_t'(DY);
        end
    end

    // A box past the left or top edge wraps to a large coordinate
    assign ctrl.within_screen = (pos_x <= coord_t'(SCREEN_W - SPRITE_SIZE))
                              & (pos_y <= coord_t'(SCREEN_H - SPRITE_SIZE));

    // Offset from the box corner, modulo the coordinate range
    assign rel_x = scan.x - pos_x;
    assign rel_y = scan.y - pos_y;

    assign hit = (rel_x < coord_t'(SPRITE_SIZE)) & (rel_y < coord_t'(SPRITE_SIZE));

    // Load and move must not collide
    no_load_while_moving: assert property (@(posedge clk) disable iff (reset)
        !(ctrl.write_xy && ctrl.enable_update));

endmodule

//--- hw/raster_scan.sv
module raster_scan
    import game_pkg::*;
#(
    parameter int SCREEN_W = 640,
    parameter int SCREEN_H = 480
)
(
    input  logic         clk,
    input  logic         reset,
    pixel_scan_if.source scan
);

    logic last_x;
    logic last_y;

    assign last_x = (scan.x == coord_t'(SCREEN_W - 1));
    assign last_y = (scan.y == coord_t'(SCREEN_H - 1));

    assign scan.frame_end = scan.valid & last_x & last_y;

    // x runs fastest, then y, then back to the origin
    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            scan.x     <= '0;
            scan.y     <= '0;
            scan.valid <= 1'b0;
        end
        else
        begin
            scan.valid <= 1'b1;  // Scan never stalls

            if (scan.valid)
            begin
                if (last_x)
                begin
                    scan.x <= '0;
                    scan.y <= last_y ? '0 : scan.y + 1'b1;
                end
                else
                begin
                    scan.x <= scan.x + 1'b1;
                end
            end
        end
    end

    scan_in_range: assert property (@(posedge clk) disable iff (reset)
        scan.x < coord_t'(SCREEN_W) && scan.y < coord_t'(SCREEN_H));

endmodule

//--- hw/game_if.sv
// Control bundle between the game FSM and one sprite
interface sprite_ctrl_if ();

    logic write_xy;       // Load start position
    logic write_dxy;      // Load velocity
    logic enable_update;  // Move at end of frame
    logic within_screen;  // Whole box is on screen

    modport master
    (
        output write_xy,
        output write_dxy,
        output enable_update,
        input  within_screen
    );

    modport sprite
    (
        input  write_xy,
        input  write_dxy,
        input  enable_update,
        output within_screen
    );

endinterface

// Current scan pixel, shared by the sprites and the mixer
interface pixel_scan_if import game_pkg::*; ();

    coord_t x;
    coord_t y;
    logic   valid;
    logic   frame_end;  // Last pixel of the frame

    modport source
    (
        output x,
        output y,
        output valid,
        output frame_end
    );

    modport sink
    (
        input x,
        input y,
        input valid,
        input frame_end
    );

endinterface

//--- hw/game_pkg.sv
package game_pkg;

    // Pixel coordinate on screen, enough for 1024 columns or rows
    typedef logic [9:0] coord_t;

    // Per-frame sprite velocity
    typedef logic signed [3:0] delta_t;

    // One bit each for red, green and blue
    typedef logic [2:0] rgb_t;

    // Side of the square sprite box
    localparam int SPRITE_SIZE = 8;

    // Colour order is {red, green, blue}
    localparam rgb_t COLOR_BACKGROUND = 3'b000;  // Black
    localparam rgb_t COLOR_TARGET     = 3'b110;  // Yellow
    localparam rgb_t COLOR_TORPEDO    = 3'b011;  // Cyan

endpackage
